//--- src.f
logic/riscvPkg.sv
logic/controller.sv
logic/aluUnit.sv
logic/regFile.sv
logic/immGen.sv
logic/instMem.sv
logic/dataMem.sv
logic/cpuTop.sv
testbench/cpuTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cpuTb
FILELIST  = src.f
OBJDIR    = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJDIR)

//--- testbench/cpuTb.sv
`timescale 1ns/1ps

module cpuTb import riscvPkg::*; ();

    localparam int CLK_HALF = 50;
    localparam int RESET_CYCLES = 16;
    // Longest program load and longest run of any test
    localparam int LOAD_MAX = 60;
    localparam int RUN_MAX = 200;
    localparam int NUM_TESTS = 5;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (LOAD_MAX + RUN_MAX);

    // RV32I major opcodes and fixed SYSTEM words
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LOAD = 7'b0000011;
    localparam logic [6:0] OP_JALR = 7'b1100111;
    localparam logic [6:0] OP_LUI = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [31:0] ECALL_WORD = 32'h00000073;
    localparam logic [31:0] EBREAK_WORD = 32'h00100073;

    logic               clk;
    logic               rstN;
    logic               imemWe;
    logic [IMEM_AW-1:0] imemAddr;
    logic [31:0]        imemWdata;
    logic [31:0]        switchIn;
    logic [31:0]        ledOut;
    logic               printValid;
    logic [31:0]        printData;
    logic               readReq;
    logic [31:0]        readValue;
    logic               halted;

    // Program image, expected prints, captured prints
    logic [31:0] prog [$];
    logic [31:0] expQ [$];
    logic [31:0] printed [$];
    logic [31:0] rngState = 32'd21366;
    int          readCount = 0;
    int          printStart = 0;
    int          readStart = 0;
    int          testErrors = 0;
    int          totalErrors = 0;
    int          testsOk = 0;
    int          cycleCount = 0;

    cpuTop cpuTop_inst (
        .clk(clk), .rstN(rstN), .imemWe(imemWe), .imemAddr(imemAddr),
        .imemWdata(imemWdata), .switchIn(switchIn), .ledOut(ledOut),
        .printValid(printValid), .printData(printData), .readReq(readReq),
        .readValue(readValue), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // --------------------
    // Watchdog and capture
    // --------------------
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Mid-cycle sample, strobes ignored while in reset
    always @(negedge clk) begin
        if (rstN && printValid) begin
            printed.push_back(printData);
        end
        if (rstN && readReq) begin
            readCount = readCount + 1;
        end
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // --------------------
    // Instruction encoders
    // --------------------
    function automatic logic [31:0] rType(input int funct7, input int rs2, input int rs1,
                                          input int funct3, input int rd);
        return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(input int imm, input int rs1, input int funct3,
                                          input int rd, input logic [6:0] opcode);
        return {imm[11:0], rs1[4:0], funct3[2:0], rd[4:0], opcode};
    endfunction

    // SW only
    function automatic logic [31:0] sType(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] bType(input int off, input int rs2, input int rs1,
                                          input int funct3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], funct3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] uType(input int imm20, input int rd,
                                          input logic [6:0] opcode);
        return {imm20[19:0], rd[4:0], opcode};
    endfunction

    // JAL, byte offset
    function automatic logic [31:0] jType(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    // --------------------
    // Program building
    // --------------------
    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic addi(input int rd, input int rs1, input int imm);
        emit(iType(imm, rs1, 0, rd, OP_IMM));
    endtask

    // Always LUI plus ADDI, upper part rounded for the signed low half
    task automatic loadConst(input int rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = (value + 32'h800) >> 12;
        emit(uType(int'(upper), rd, OP_LUI));
        emit(iType(int'(value), rd, 0, rd, OP_IMM));
    endtask

    // a0 from rs, service 1 in a7
    task automatic printReg(input int rs);
        addi(10, rs, 0);
        addi(17, 0, 1);
        emit(ECALL_WORD);
    endtask

    // x7 = x5 op x6, printed
    task automatic runRegOp(input int funct7, input int funct3, input logic [31:0] expected);
        emit(rType(funct7, 6, 5, funct3, 7));
        printReg(7);
        expQ.push_back(expected);
    endtask

    task automatic beginTest();
        prog.delete();
        expQ.delete();
        testErrors = 0;
    endtask

    // Load during reset, release, run until halted
    task automatic loadAndRun();
        int cycles;
        cycles = (prog.size() > RESET_CYCLES) ? prog.size() : RESET_CYCLES;
        @(posedge clk);
        rstN <= 1'b0;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            if (i < prog.size()) begin
                imemWe <= 1'b1;
                imemAddr <= i[IMEM_AW-1:0];
                imemWdata <= prog[i];
            end else begin
                imemWe <= 1'b0;
            end
        end
        @(posedge clk);
        imemWe <= 1'b0;
        printStart = printed.size();
        readStart = readCount;
        rstN <= 1'b1;
        while (!halted) begin
            @(negedge clk);
        end
    endtask

    // --------------------
    // Checking
    // --------------------
    task automatic checkValue(input string sig, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s expected 0x%08h, got 0x%08h",
                     $time, sig, expected, actual);
            testErrors++;
        end
    endtask

    task automatic comparePrints();
        int count;
        count = printed.size() - printStart;
        if (count != expQ.size()) begin
            $display("** Error at time %0t: printValid count expected %0d, got %0d",
                     $time, expQ.size(), count);
            testErrors++;
        end
        for (int i = 0; i < expQ.size() && i < count; i++) begin
            checkValue($sformatf("printData[%0d]", i), expQ[i], printed[printStart + i]);
        end
    endtask

    task automatic reportTest(input string name);
        if (testErrors == 0) begin
            testsOk++;
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, testErrors);
        end
        totalErrors += testErrors;
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic testArithmetic();
        logic [31:0] a;
        logic [31:0] b;
        beginTest();
        a = nextRandom();
        b = nextRandom();
        loadConst(5, a);
        loadConst(6, b);
        printReg(5);
        expQ.push_back(a);
        runRegOp(0, 0, a + b);
        runRegOp(32, 0, a - b);
        runRegOp(0, 7, a & b);
        runRegOp(0, 6, a | b);
        runRegOp(0, 4, a ^ b);
        runRegOp(0, 2, {31'd0, $signed(a) < $signed(b)});
        runRegOp(0, 3, {31'd0, a < b});
        // Shift amount is rs2[4:0]
        runRegOp(0, 1, a << b[4:0]);
        runRegOp(0, 5, a >> b[4:0]);
        runRegOp(32, 5, $signed(a) >>> b[4:0]);
        emit(EBREAK_WORD);
        loadAndRun();
        comparePrints();
        reportTest("arithmetic");
    endtask

    task automatic testMemory();
        logic [31:0] vals [4];
        int          addrs [4];
        beginTest();
        addrs = '{16, 132, 512, 1020};
        for (int i = 0; i < 4; i++) begin
            vals[i] = nextRandom();
            loadConst(5, vals[i]);
            emit(sType(addrs[i], 5, 0));
        end
        for (int i = 0; i < 4; i++) begin
            emit(iType(addrs[i], 0, 2, 7, OP_LOAD));
            printReg(7);
            expQ.push_back(vals[i]);
        end
        // Word 0x100 never stored
        emit(iType(256, 0, 2, 7, OP_LOAD));
        printReg(7);
        expQ.push_back(32'd0);
        emit(EBREAK_WORD);
        loadAndRun();
        comparePrints();
        reportTest("memory");
    endtask

    task automatic testControlFlow();
        int n;
        int jalIdx;
        beginTest();
        n = int'(nextRandom() % 32'd8) + 5;
        // Sum n down to 1, loop body at word 2
        addi(5, 0, n);
        addi(6, 0, 0);
        emit(rType(0, 5, 6, 0, 6));
        addi(5, 5, -1);
        emit(bType(-8, 0, 5, 1));
        printReg(6);
        expQ.push_back(n * (n + 1) / 2);
        // BLT taken on -3 < 2, skips the bad marker
        addi(5, 0, -3);
        addi(6, 0, 2);
        addi(7, 0, 'h11);
        emit(bType(8, 6, 5, 4));
        addi(7, 0, 'h7FF);
        printReg(7);
        expQ.push_back(32'h11);
        // BGEU taken, -3 is huge unsigned
        addi(7, 0, 'h22);
        emit(bType(8, 6, 5, 7));
        addi(7, 0, 'h7FF);
        printReg(7);
        expQ.push_back(32'h22);
        // BEQ not taken
        addi(7, 0, 'h55);
        emit(bType(8, 6, 5, 0));
        addi(7, 0, 'h66);
        printReg(7);
        expQ.push_back(32'h66);
        // JAL over the bad marker, link in x1
        addi(7, 0, 'h33);
        jalIdx = prog.size();
        emit(jType(8, 1));
        addi(7, 0, 'h7FF);
        printReg(7);
        printReg(1);
        expQ.push_back(32'h33);
        expQ.push_back(jalIdx * 4 + 4);
        // JALR to base + 17, bit 0 dropped, lands on the print
        emit(uType(0, 8, OP_AUIPC));
        addi(7, 0, 'h44);
        emit(iType(17, 8, 0, 0, OP_JALR));
        addi(7, 0, 'h7FF);
        printReg(7);
        expQ.push_back(32'h44);
        emit(EBREAK_WORD);
        loadAndRun();
        comparePrints();
        reportTest("control flow");
    endtask

    task automatic testIo();
        logic [31:0] switches;
        logic [31:0] supplied;
        beginTest();
        switches = nextRandom();
        supplied = nextRandom();
        @(posedge clk);
        switchIn <= switches;
        readValue <= supplied;
        // x8 at the I/O page
        loadConst(8, 32'hFFFFFC00);
        emit(iType(0, 8, 2, 5, OP_LOAD));
        emit(sType(4, 5, 8));
        printReg(5);
        expQ.push_back(switches);
        // Service 5 fills a0
        addi(17, 0, 5);
        emit(ECALL_WORD);
        printReg(10);
        expQ.push_back(supplied);
        emit(EBREAK_WORD);
        loadAndRun();
        comparePrints();
        checkValue("ledOut", switches, ledOut);
        if (readCount - readStart != 1) begin
            $display("readReq strobed %0d times instead of once", readCount - readStart);
            testErrors++;
        end
        reportTest("io and read service");
    endtask

    task automatic testHalt();
        logic [31:0] ledValue;
        beginTest();
        ledValue = nextRandom();
        loadConst(8, 32'hFFFFFC00);
        loadConst(5, ledValue);
        emit(sType(0, 5, 8));
        printReg(5);
        expQ.push_back(ledValue);
        emit(EBREAK_WORD);
        // Past the halt, must never take effect
        addi(6, 0, 'h123);
        printReg(6);
        emit(sType(0, 6, 8));
        emit(EBREAK_WORD);
        loadAndRun();
        repeat (10) @(negedge clk);
        if (!halted) begin
            $display("halted dropped after EBREAK");
            testErrors++;
        end
        comparePrints();
        checkValue("ledOut", ledValue, ledOut);
        reportTest("halt");
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        rstN <= 1'b0;
        imemWe <= 1'b0;
        imemAddr <= '0;
        imemWdata <= '0;
        switchIn <= '0;
        readValue <= '0;
        testArithmetic();
        testMemory();
        testControlFlow();
        testIo();
        testHalt();
        $display("Tests ok: %0d of %0d, errors: %0d", testsOk, NUM_TESTS, totalErrors);
        if (totalErrors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- logic/cpuTop.sv
`timescale 1ns/1ps

module cpuTop import riscvPkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  logic               imemWe,
    input  logic [IMEM_AW-1:0] imemAddr,
    input  logic [31:0]        imemWdata,
    input  logic [31:0]        switchIn,
    output logic [31:0]        ledOut,
    output logic               printValid,
    output logic [31:0]        printData,
    output logic               readReq,
    input  logic [31:0]        readValue,
    output logic               halted
);
    logic [31:0] pc;
    logic [31:0] pcPlus4;
    logic [31:0] nextPc;
    logic [31:0] inst;
    logic [31:0] imm;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] a0Data;
    logic [31:0] a7Data;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] aluResult;
    logic [31:0] memRdData;
    logic [31:0] wbData;
    logic [4:0]  rdSel;
    logic [1:0]  aluOp;
    logic [11:0] ecallOp;
    logic        branchCond;
    logic        branch;
    logic        jump;
    logic        jalr;
    logic        aluSrc;
    logic        memRead;
    logic        memWrite;
    logic        memToReg;
    logic        regWrite;
    logic        ioRead;
    logic        ioWrite;
    logic        eRead;
    logic        eWrite;
    logic        eBreak;
    logic        run;

    // Writes only while out of reset and not halted
    assign run = rstN && !halted;

    // --------------------
    // PC and halt
    // --------------------
    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        if (jalr) begin
            // Target from the ALU, bit 0 cleared
            nextPc = {aluResult[31:1], 1'b0};
        end else if (branch || jump) begin
            nextPc = pc + imm;
        end else begin
            nextPc = pcPlus4;
        end
    end

    // EBREAK leaves the PC on itself
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
            halted <= 1'b0;
        end else if (!halted) begin
            if (eBreak) begin
                halted <= 1'b1;
            end else begin
                pc <= nextPc;
            end
        end
    end

    instMem instMem_inst (
        .clk(clk), .pc(pc), .loadEn(imemWe), .loadAddr(imemAddr), .loadData(imemWdata),
        .inst(inst)
    );

    controller controller_inst (
        .inst(inst), .aluResult(aluResult), .zero(branchCond), .ecallCode(a7Data),
        .branch(branch), .jump(jump), .jalr(jalr), .aluOp(aluOp), .aluSrc(aluSrc),
        .memRead(memRead), .memWrite(memWrite), .memToReg(memToReg), .regWrite(regWrite),
        .ioRead(ioRead), .ioWrite(ioWrite), .eRead(eRead), .eWrite(eWrite),
        .ecallOp(ecallOp), .eBreak(eBreak)
    );

    immGen immGen_inst (
        .inst(inst), .imm(imm)
    );

    // ECALL read lands in a0
    assign rdSel = eRead ? 5'd10 : inst[11:7];

    regFile regFile_inst (
        .clk(clk), .rstN(rstN), .rs1(inst[19:15]), .rs2(inst[24:20]), .rd(rdSel),
        .wrEn((regWrite || eRead) && run), .wrData(wbData),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .a0Data(a0Data), .a7Data(a7Data)
    );

    // --------------------
    // Execute
    // --------------------
    // AUIPC adds to the PC instead of rs1
    assign opA = (inst[6:0] == OPCODE_AUIPC) ? pc : rs1Data;
    assign opB = aluSrc ? imm : rs2Data;

    aluUnit aluUnit_inst (
        .aluOp(aluOp), .funct3(inst[14:12]), .funct7b5(inst[30]), .opA(opA), .opB(opB),
        .aluResult(aluResult), .branchCond(branchCond)
    );

    dataMem dataMem_inst (
        .clk(clk), .rstN(rstN), .addr(aluResult), .wrData(rs2Data),
        .memRead(memRead), .memWrite(memWrite && run), .ioRead(ioRead),
        .ioWrite(ioWrite && run), .switchIn(switchIn), .rdData(memRdData), .ledOut(ledOut)
    );

    // Write-back select
    always_comb begin
        if (eRead) begin
            wbData = readValue;
        end else if (jump || jalr) begin
            wbData = pcPlus4;
        end else if (memToReg) begin
            wbData = memRdData;
        end else begin
            wbData = aluResult;
        end
    end

    // ECALL strobes, one per executed instruction
    assign printValid = eWrite && (ecallOp == EOP_PRINT_INT) && !halted;
    assign printData = a0Data;
    assign readReq = eRead && (ecallOp == EOP_READ_INT) && !halted;

    assert property (@(posedge clk) imemWe |-> !rstN)
        else $error("cpuTop: program load while the core runs");

    // Halt freezes fetch and the LEDs
    assert property (@(posedge clk) disable iff (!rstN)
                     halted |=> halted && $stable(pc) && $stable(ledOut))
        else $error("cpuTop: state changed after halt");

endmodule

//--- logic/dataMem.sv
`timescale 1ns/1ps

module dataMem import riscvPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] addr,
    input  logic [31:0] wrData,
    input  logic        memRead,
    input  logic        memWrite,
    input  logic        ioRead,
    input  logic        ioWrite,
    input  logic [31:0] switchIn,
    output logic [31:0] rdData,
    output logic [31:0] ledOut
);
    logic [31:0]        mem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] wordIdx;

    // Word addressing only
    assign wordIdx = addr[DMEM_AW+1:2];

    // Power-up contents of the block RAM
    initial begin
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // --------------------
    // Word array
    // --------------------
    always_ff @(posedge clk) begin
        if (memWrite) begin
            mem[wordIdx] <= wrData;
        end
    end

    // --------------------
    // I/O window
    // --------------------
    // LED register, any store into the window
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ledOut <= '0;
        end else if (ioWrite) begin
            ledOut <= wrData;
        end
    end

    // Switches win over the array for window loads
    always_comb begin
        if (ioRead) begin
            rdData = switchIn;
        end else if (memRead) begin
            rdData = mem[wordIdx];
        end else begin
            rdData = '0;
        end
    end

endmodule

//--- logic/instMem.sv
`timescale 1ns/1ps

module instMem import riscvPkg::*; (
    input  logic               clk,
    input  logic [31:0]        pc,
    input  logic               loadEn,
    input  logic [IMEM_AW-1:0] loadAddr,
    input  logic [31:0]        loadData,
    output logic [31:0]        inst
);
    logic [31:0]        mem [IMEM_DEPTH];
    logic [IMEM_AW-1:0] fetchIdx;

    // Word index, byte offset dropped
    assign fetchIdx = pc[IMEM_AW+1:2];

    // --------------------
    // Load port
    // --------------------
    // Program image written one word per cycle
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end
    end

    // Fetch is combinational
    assign inst = mem[fetchIdx];

endmodule

//--- logic/immGen.sv
`timescale 1ns/1ps

module immGen import riscvPkg::*; (
    input  logic [31:0] inst,
    output logic [31:0] imm
);
    logic [6:0] opcode;
    logic       sign;

    assign opcode = inst[6:0];
    // Sign bit sits at 31 in every format
    assign sign = inst[31];

    always_comb begin
        case (opcode)
            // I format, also loads and JALR
            OPCODE_I, OPCODE_L, OPCODE_JALR: begin
                imm = {{20{sign}}, inst[31:20]};
            end
            // S format, split field
            OPCODE_S: begin
                imm = {{20{sign}}, inst[31:25], inst[11:7]};
            end
            // B format, halfword offset
            OPCODE_B: begin
                imm = {{19{sign}}, sign, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            // U format, upper 20 bits
            OPCODE_LUI, OPCODE_AUIPC: begin
                imm = {inst[31:12], 12'd0};
            end
            // J format
            OPCODE_JAL: begin
                imm = {{11{sign}}, sign, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        wrEn,
    input  logic [31:0] wrData,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data,
    output logic [31:0] a0Data,
    output logic [31:0] a7Data
);
    logic [31:0] regs [32];

    // Whole file cleared on reset and x0 never written
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && rd != 5'd0) begin
            regs[rd] <= wrData;
        end
    end

    // Asynchronous reads
    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

    // --------------------
    // ECALL argument taps
    // --------------------
    // a0 holds the value, a7 the service
    assign a0Data = regs[10];
    assign a7Data = regs[17];

endmodule

//--- logic/aluUnit.sv
`timescale 1ns/1ps

module aluUnit import riscvPkg::*; (
    input  logic [1:0]  aluOp,
    input  logic [2:0]  funct3,
    input  logic        funct7b5,
    input  logic [31:0] opA,
    input  logic [31:0] opB,
    output logic [31:0] aluResult,
    output logic        branchCond
);
    aluSel_t     aluSel;
    logic [4:0]  shamt;
    logic        signedLt;
    logic        unsignedLt;

    assign shamt = opB[4:0];
    assign signedLt = $signed(opA) < $signed(opB);
    assign unsignedLt = opA < opB;

    // --------------------
    // Operation select
    // --------------------
    always_comb begin
        aluSel = ALU_ADD;
        case (aluOp)
            ALUOP_MEM: aluSel = ALU_ADD;
            ALUOP_BRANCH: aluSel = ALU_PASSB;
            ALUOP_R, ALUOP_I: begin
                case (funct3)
                    3'b000: begin
                        // SUB exists only in R form
                        if (aluOp == ALUOP_R && funct7b5) begin
                            aluSel = ALU_SUB;
                        end
                    end
                    3'b001: aluSel = ALU_SLL;
                    3'b010: aluSel = ALU_SLT;
                    3'b011: aluSel = ALU_SLTU;
                    3'b100: aluSel = ALU_XOR;
                    3'b101: begin
                        if (funct7b5) begin
                            aluSel = ALU_SRA;
                        end else begin
                            aluSel = ALU_SRL;
                        end
                    end
                    3'b110: aluSel = ALU_OR;
                    default: aluSel = ALU_AND;
                endcase
            end
            default: aluSel = ALU_ADD;
        endcase
    end

    always_comb begin
        case (aluSel)
            ALU_ADD: aluResult = opA + opB;
            ALU_SUB: aluResult = opA - opB;
            ALU_SLL: aluResult = opA << shamt;
            ALU_SLT: aluResult = {31'd0, signedLt};
            ALU_SLTU: aluResult = {31'd0, unsignedLt};
            ALU_XOR: aluResult = opA ^ opB;
            ALU_SRL: aluResult = opA >> shamt;
            ALU_SRA: aluResult = $signed(opA) >>> shamt;
            ALU_OR: aluResult = opA | opB;
            ALU_AND: aluResult = opA & opB;
            default: aluResult = opB;
        endcase
    end

    // Branch compare on rs1 and rs2
    always_comb begin
        case (funct3)
            3'b000: branchCond = opA == opB;
            3'b001: branchCond = opA != opB;
            3'b100: branchCond = signedLt;
            3'b101: branchCond = !signedLt;
            3'b110: branchCond = unsignedLt;
            3'b111: branchCond = !unsignedLt;
            default: branchCond = 1'b0;
        endcase
    end

endmodule

//--- logic/controller.sv
`timescale 1ns/1ps

module controller import riscvPkg::*; (
    input  logic [31:0] inst,
    input  logic [31:0] aluResult,
    input  logic        zero,
    input  logic [31:0] ecallCode,
    output logic        branch,
    output logic        jump,
    output logic        jalr,
    output logic [1:0]  aluOp,
    output logic        aluSrc,
    output logic        memRead,
    output logic        memWrite,
    output logic        memToReg,
    output logic        regWrite,
    output logic        ioRead,
    output logic        ioWrite,
    output logic        eRead,
    output logic        eWrite,
    output logic [11:0] ecallOp,
    output logic        eBreak
);
    logic [6:0]  opcode;
    logic [11:0] imm12;
    logic        isLoad;
    logic        isStore;
    logic        inIoWindow;

    assign opcode = inst[6:0];
    assign imm12 = inst[31:20];
    assign isLoad = opcode == OPCODE_L;
    assign isStore = opcode == OPCODE_S;
    // Effective address lands in the FFFFFCxx page
    assign inIoWindow = aluResult[31:8] == IO_BASE_HI;

    // --------------------
    // Datapath control
    // --------------------
    // zero carries the branch condition for this funct3
    assign branch = (opcode == OPCODE_B) && zero;
    assign jump = opcode == OPCODE_JAL;
    assign jalr = opcode == OPCODE_JALR;

    always_comb begin
        case (opcode)
            OPCODE_R: aluOp = ALUOP_R;
            OPCODE_I: aluOp = ALUOP_I;
            OPCODE_B, OPCODE_LUI: aluOp = ALUOP_BRANCH;
            default: aluOp = ALUOP_MEM;
        endcase
    end

    // JALR target comes out of the ALU as rs1 + imm
    assign aluSrc = (opcode == OPCODE_I) || isLoad || isStore || (opcode == OPCODE_LUI)
                    || (opcode == OPCODE_AUIPC) || (opcode == OPCODE_JALR);
    assign regWrite = (opcode == OPCODE_R) || (opcode == OPCODE_I) || isLoad
                      || (opcode == OPCODE_LUI) || (opcode == OPCODE_AUIPC) || jump || jalr;
    assign memToReg = isLoad;

    // Window decides memory or I/O
    assign memRead = isLoad && !inIoWindow;
    assign memWrite = isStore && !inIoWindow;
    assign ioRead = isLoad && inIoWindow;
    assign ioWrite = isStore && inIoWindow;

    // --------------------
    // SYSTEM
    // --------------------
    assign eBreak = (opcode == OPCODE_E) && (imm12 == INST_EBREAK);

    always_comb begin
        eWrite = 1'b0;
        eRead = 1'b0;
        ecallOp = '0;
        if (opcode == OPCODE_E && imm12 == INST_ECALL) begin
            // Unknown services fall through as no-ops
            if (ecallCode == {20'd0, EOP_PRINT_INT}) begin
                eWrite = 1'b1;
                ecallOp = EOP_PRINT_INT;
            end else if (ecallCode == {20'd0, EOP_READ_INT}) begin
                eRead = 1'b1;
                ecallOp = EOP_READ_INT;
            end
        end
    end

endmodule

//--- logic/riscvPkg.sv
package riscvPkg;

    // --------------------
    // Opcodes
    // --------------------
    localparam logic [6:0] OPCODE_R     = 7'b0110011;
    localparam logic [6:0] OPCODE_I     = 7'b0010011;
    localparam logic [6:0] OPCODE_L     = 7'b0000011;
    localparam logic [6:0] OPCODE_S     = 7'b0100011;
    localparam logic [6:0] OPCODE_B     = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL   = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR  = 7'b1100111;
    localparam logic [6:0] OPCODE_LUI   = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC = 7'b0010111;
    // SYSTEM, split by imm12 below
    localparam logic [6:0] OPCODE_E     = 7'b1110011;

    // imm12 of the two SYSTEM instructions
    localparam logic [11:0] INST_ECALL  = 12'h000;
    localparam logic [11:0] INST_EBREAK = 12'h001;

    // ECALL services, selected by a7
    localparam logic [11:0] EOP_PRINT_INT = 12'd1;
    localparam logic [11:0] EOP_READ_INT  = 12'd5;

    // Upper address bits of the I/O window
    localparam logic [23:0] IO_BASE_HI = 24'hFFFFFC;

    // --------------------
    // ALU
    // --------------------
    // Add for addresses, PC-relative and jumps
    localparam logic [1:0] ALUOP_MEM    = 2'b00;
    // Compare lives in the branch unit, result passes opB
    localparam logic [1:0] ALUOP_BRANCH = 2'b01;
    localparam logic [1:0] ALUOP_R      = 2'b10;
    localparam logic [1:0] ALUOP_I      = 2'b11;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        // LUI immediate straight through
        ALU_PASSB
    } aluSel_t;

    // Memory sizes in words
    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

endpackage
